// File: hdl/mem_test_cfg.svh
// Width settings for the memory read-bandwidth test engine
// Included by the package, which builds the shared types from these values

`ifndef MEM_TEST_CFG_SVH
`define MEM_TEST_CFG_SVH

// ======================================================================
// Data path widths
// ======================================================================

// Cache-line address and buffer offset width
`define MEM_TEST_ADDR_BITS 42

// Stride and base rotation width
`define MEM_TEST_STRIDE_BITS 16

// Offered-load reload interval width
`define MEM_TEST_INTERVAL_BITS 8

// Cycle, response and in-flight counters
// Host keeps run_cycles below 2^31 so cycles plus drain fit the counter
`define MEM_TEST_CNT_BITS 32

`endif

// File: hdl/mem_test_pkg.sv
// Shared types for the memory read-bandwidth test engine
// Every RTL module imports this package by wildcard

package mem_test_pkg;

    `include "mem_test_cfg.svh"

    // ==================================================================
    // Vector types
    // ==================================================================

    // Cache-line address or offset inside the test buffer
    typedef logic [`MEM_TEST_ADDR_BITS-1:0]     line_addr_t;

    // Walk stride and base rotation point
    typedef logic [`MEM_TEST_STRIDE_BITS-1:0]   stride_t;

    // Pacing reload value, one request per interval plus one cycles
    typedef logic [`MEM_TEST_INTERVAL_BITS-1:0] interval_t;

    // Statistics and cycle counters
    typedef logic [`MEM_TEST_CNT_BITS-1:0]      counter_t;

    // Run FSM encoding
    typedef enum logic [1:0]
    {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_DRAIN
    } run_state_t;

    // ==================================================================
    // Host configuration and run results
    // ==================================================================

    // Held stable by the host from start until done
    typedef struct packed
    {
        line_addr_t rd_base;
        line_addr_t mem_mask;
        stride_t    stride;
        interval_t  req_interval;
        counter_t   run_cycles;
    } test_cfg_t;

    // Valid from done until the next start
    typedef struct packed
    {
        counter_t cycles_executed;
        counter_t rsp_count;
        counter_t inflight_max;
    } test_result_t;

endpackage

// File: hdl/mem_test_top.sv
// Top of the memory read-bandwidth test engine
// Host loads cfg, pulses start and collects result when done pulses

`timescale 1ns/10ps

module mem_test_top
    import mem_test_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  test_cfg_t    cfg,
    input  logic         start,
    input  logic         rd_almost_full,
    input  logic         rsp_valid,
    output logic         req_valid,
    output line_addr_t   req_addr,
    output logic         busy,
    output logic         done,
    output test_result_t result
);

    // Control
    logic       start_run;
    run_state_t run_state;

    // Producer to walker and statistics
    logic       issue;
    line_addr_t offset;

    // Statistics
    counter_t   inflight_now;
    counter_t   rsp_count;
    counter_t   inflight_max;
    counter_t   cycles_executed;

    // ==================================================================
    // Control
    // ==================================================================

    run_ctrl run_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .run_cycles      (cfg.run_cycles),
        .inflight_now    (inflight_now),
        .req_valid       (req_valid),
        .start_run       (start_run),
        .run_state       (run_state),
        .busy            (busy),
        .done            (done),
        .cycles_executed (cycles_executed)
    );

    // ==================================================================
    // Request side
    // ==================================================================

    rd_addr_walker rd_addr_walker_inst (
        .clk       (clk),
        .reset     (reset),
        .start_run (start_run),
        .issue     (issue),
        .stride    (cfg.stride),
        .mem_mask  (cfg.mem_mask),
        .offset    (offset)
    );

    rd_req_gen rd_req_gen_inst (
        .clk            (clk),
        .reset          (reset),
        .start_run      (start_run),
        .run_state      (run_state),
        .rd_almost_full (rd_almost_full),
        .req_interval   (cfg.req_interval),
        .rd_base        (cfg.rd_base),
        .offset         (offset),
        .issue          (issue),
        .req_valid      (req_valid),
        .req_addr       (req_addr)
    );

    // ==================================================================
    // Response side
    // ==================================================================

    rsp_stats rsp_stats_inst (
        .clk          (clk),
        .reset        (reset),
        .start_run    (start_run),
        .issue        (issue),
        .rsp_valid    (rsp_valid),
        .inflight_now (inflight_now),
        .rsp_count    (rsp_count),
        .inflight_max (inflight_max)
    );

    // Counters hold from done until the next start
    assign result.cycles_executed = cycles_executed;
    assign result.rsp_count       = rsp_count;
    assign result.inflight_max    = inflight_max;

endmodule

// File: hdl/rd_addr_walker.sv
// Read offset walker for the test buffer
// Steps by the stride and rotates the start point each time the walk wraps

`timescale 1ns/10ps

module rd_addr_walker
    import mem_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_run,
    input  logic       issue,
    input  stride_t    stride,
    input  line_addr_t mem_mask,
    output line_addr_t offset
);

    // Offset used by the request after the current one
    line_addr_t offset_next;

    // Start point for the next trip through the buffer
    stride_t    base_next;
    logic       base_upd;

    // Largest start point before the base wraps to zero
    stride_t    base_max;

    // Next offset left the masked region
    logic       overflow;

    assign overflow = |(offset_next & ~mem_mask);

    // ==================================================================
    // Base rotation limit
    // ==================================================================

    // Limit follows the config one cycle later
    always_ff @(posedge clk)
    begin
        if (stride == stride_t'(0))
        begin
            base_max <= stride_t'(0);
        end
        else
        begin
            // One line below the stride and kept inside the region
            base_max <= (stride - stride_t'(1)) & stride_t'(mem_mask);
        end
    end

    // ==================================================================
    // Offset walk
    // ==================================================================

    always_ff @(posedge clk)
    begin
        // Base moves on the cycle after a wrap
        if (base_upd)
        begin
            if (base_next < base_max)
            begin
                base_next <= base_next + stride_t'(1);
            end
            else
            begin
                base_next <= stride_t'(0);
            end
        end
        base_upd <= 1'b0;

        if (issue)
        begin
            if (overflow)
            begin
                // Back to the buffer head at the rotated start point
                offset      <= line_addr_t'(base_next);
                offset_next <= line_addr_t'(base_next) + line_addr_t'(stride);
                base_upd    <= 1'b1;
            end
            else
            begin
                offset      <= offset_next;
                offset_next <= offset_next + line_addr_t'(stride);
            end
        end

        // New run starts at the head with the base stepped once
        if (reset || start_run)
        begin
            offset      <= line_addr_t'(0);
            offset_next <= line_addr_t'(stride);
            base_next   <= stride_t'(0);
            base_upd    <= 1'b1;
        end
    end

endmodule

// File: hdl/rd_req_gen.sv
// Read request generator
// Paces requests at the offered load and holds off while the bus is almost full

`timescale 1ns/10ps

module rd_req_gen
    import mem_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_run,
    input  run_state_t run_state,
    input  logic       rd_almost_full,
    input  interval_t  req_interval,
    input  line_addr_t rd_base,
    input  line_addr_t offset,
    output logic       issue,
    output logic       req_valid,
    output line_addr_t req_addr
);

    // Registered back-pressure that reads full out of reset
    logic      almost_full_q;

    // Offered load pacing
    interval_t pace_cnt;
    logic      pace_en;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            almost_full_q <= 1'b1;
        end
        else
        begin
            almost_full_q <= rd_almost_full;
        end
    end

    // ==================================================================
    // Pacing counter
    // ==================================================================

    // One enable per reload and a slot missed during a stall is lost
    always_ff @(posedge clk)
    begin
        if (reset || start_run)
        begin
            pace_cnt <= interval_t'(0);
            pace_en  <= 1'b0;
        end
        else
        begin
            pace_en <= (pace_cnt == interval_t'(0));
            if (pace_cnt == interval_t'(0))
            begin
                pace_cnt <= req_interval;
            end
            else
            begin
                pace_cnt <= pace_cnt - interval_t'(1);
            end
        end
    end

    // ==================================================================
    // Request issue and output register
    // ==================================================================

    assign issue = (run_state == RUN_ACTIVE) && !almost_full_q && pace_en;

    // Address uses the walker offset before it advances on this issue
    always_ff @(posedge clk)
    begin
        req_addr <= rd_base + offset;

        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= issue;
        end
    end

endmodule

// File: hdl/rsp_stats.sv
// Read response statistics
// Counts returned lines and tracks current and peak outstanding reads

`timescale 1ns/10ps

module rsp_stats
    import mem_test_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start_run,
    input  logic     issue,
    input  logic     rsp_valid,
    output counter_t inflight_now,
    output counter_t rsp_count,
    output counter_t inflight_max
);

    // Response seen on the previous cycle
    logic rsp_q;

    // ==================================================================
    // Response counting
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset || start_run)
        begin
            rsp_q     <= 1'b0;
            rsp_count <= counter_t'(0);
        end
        else
        begin
            rsp_q <= rsp_valid;
            if (rsp_q)
            begin
                rsp_count <= rsp_count + counter_t'(1);
            end
        end
    end

    // ==================================================================
    // Outstanding reads
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset || start_run)
        begin
            inflight_now <= counter_t'(0);
            inflight_max <= counter_t'(0);
        end
        else
        begin
            // Issue and response together leave the count unchanged
            if (issue != rsp_q)
            begin
                inflight_now <= rsp_q ? inflight_now - counter_t'(1) :
                                        inflight_now + counter_t'(1);
            end

            // Peak trails the current count by a cycle
            if (inflight_now > inflight_max)
            begin
                inflight_max <= inflight_now;
            end
        end
    end

endmodule

// File: hdl/run_ctrl.sv
// Run controller for the read test engine
// Sequences idle, active and drain, and counts the cycles of each run

`timescale 1ns/10ps

module run_ctrl
    import mem_test_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  counter_t   run_cycles,
    input  counter_t   inflight_now,
    input  logic       req_valid,
    output logic       start_run,
    output run_state_t run_state,
    output logic       busy,
    output logic       done,
    output counter_t   cycles_executed
);

    // Remaining active cycles
    counter_t cycles_rem;

    // Drain is over once nothing is on the bus and nothing is outstanding
    logic can_finish;

    assign can_finish = (inflight_now == counter_t'(0)) && !req_valid;

    assign busy = (run_state != RUN_IDLE);

    // ==================================================================
    // Start pulse register
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_run <= 1'b0;
        end
        else
        begin
            start_run <= start;
        end
    end

    // ==================================================================
    // Run FSM
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_state       <= RUN_IDLE;
            cycles_rem      <= counter_t'(0);
            cycles_executed <= counter_t'(0);
            done            <= 1'b0;
        end
        else
        begin
            // Single-cycle done unless set below
            done <= 1'b0;

            case (run_state)
                RUN_IDLE:
                begin
                    // Last count stays visible until a new run begins
                    if (start_run)
                    begin
                        run_state       <= RUN_ACTIVE;
                        cycles_rem      <= run_cycles;
                        cycles_executed <= counter_t'(0);
                    end
                end

                RUN_ACTIVE:
                begin
                    if (cycles_rem == counter_t'(0))
                    begin
                        run_state <= RUN_DRAIN;
                    end
                    else
                    begin
                        cycles_rem <= cycles_rem - counter_t'(1);
                    end
                    cycles_executed <= cycles_executed + counter_t'(1);
                end

                RUN_DRAIN:
                begin
                    // Wait for the last reads to come back
                    if (can_finish)
                    begin
                        run_state <= RUN_IDLE;
                        done      <= 1'b1;
                    end
                    cycles_executed <= cycles_executed + counter_t'(1);
                end

                default:
                begin
                    run_state <= RUN_IDLE;
                end
            endcase
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the test engine simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
    -f sources.f --top-module mem_test_tb -o mem_test_sim

# The simulator exits nonzero on a failed check, the log decides the result
./obj_dir/mem_test_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation PASSED"

// File: sim/mem_test_tb_tasks.svh
// Compare tasks, bounded waits and the reference walker for the engine testbench
// Included inside the testbench module, which declares the signals used here

`ifndef MEM_TEST_TB_TASKS_SVH
`define MEM_TEST_TB_TASKS_SVH

// ======================================================================
// Failure reporting and compares
// ======================================================================

// Stop at the first error
task automatic abort_sim();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_sim();
endtask

task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
    if (got !== exp)
    begin
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        abort_sim();
    end
endtask

task automatic check_count(input string name, input counter_t got, input counter_t exp);
    if (got !== exp)
    begin
        $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        abort_sim();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        abort_sim();
    end
endtask

// ======================================================================
// Bounded waits on the falling edge
// ======================================================================

task automatic wait_for_busy(input int limit);
    int   i;
    logic seen;

    seen = 1'b0;
    for (i = 0; i < limit && !seen; i++)
    begin
        @(negedge clk);
        seen = busy;
    end
    if (!seen)
    begin
        report_error("engine did not leave idle after start");
    end
endtask

task automatic wait_for_done(input int limit);
    int   i;
    logic seen;

    seen = 1'b0;
    for (i = 0; i < limit && !seen; i++)
    begin
        @(negedge clk);
        seen = done;
    end
    if (!seen)
    begin
        report_error("timeout waiting for done");
    end
endtask

// ======================================================================
// Reference walker
// ======================================================================

// Base steps up to one below the stride, inside the mask, then wraps
function automatic stride_t rotated_base(input stride_t base);
    stride_t limit;

    if (cfg.stride == stride_t'(0))
    begin
        limit = stride_t'(0);
    end
    else
    begin
        limit = (cfg.stride - stride_t'(1)) & cfg.mem_mask[15:0];
    end
    if (base < limit)
    begin
        return base + stride_t'(1);
    end
    return stride_t'(0);
endfunction

// Head of the buffer with the base already stepped once
task automatic reset_walker();
    m_off      = '0;
    m_nxt      = line_addr_t'(cfg.stride);
    m_base     = rotated_base(stride_t'(0));
    m_base_upd = 1'b0;
endtask

// One cycle of the walk where a request seen here was issued a cycle earlier
task automatic advance_walker(input logic issued);
    logic    upd_prev;
    stride_t base_prev;

    upd_prev   = m_base_upd;
    base_prev  = m_base;
    m_base_upd = 1'b0;
    if (issued)
    begin
        check_addr("req_addr", req_addr, cfg.rd_base + m_off);
        if (|(m_nxt & ~cfg.mem_mask))
        begin
            // Wrap to the rotated start and move the base a cycle later
            m_off      = line_addr_t'(base_prev);
            m_nxt      = line_addr_t'(base_prev) + line_addr_t'(cfg.stride);
            m_base_upd = 1'b1;
        end
        else
        begin
            m_off = m_nxt;
            m_nxt = m_nxt + line_addr_t'(cfg.stride);
        end
    end
    if (upd_prev)
    begin
        m_base = rotated_base(base_prev);
    end
endtask

// ======================================================================
// One full run with a random configuration
// ======================================================================

task automatic run_one_test(input int index);
    logic [31:0] r0;
    logic [31:0] r1;
    int          mask_bits;

    r0 = $urandom();
    r1 = $urandom();
    cfg.rd_base  = {r1[9:0], r0};
    mask_bits    = $urandom_range(0, 12);
    cfg.mem_mask = (line_addr_t'(1) << mask_bits) - line_addr_t'(1);
    case ($urandom_range(0, 3))
        0: cfg.stride = stride_t'(0);
        // Stride past the whole region so every step wraps
        1: cfg.stride = stride_t'(cfg.mem_mask) + stride_t'($urandom_range(1, 64));
        default: cfg.stride = stride_t'($urandom_range(1, 40));
    endcase
    cfg.req_interval = interval_t'($urandom_range(0, 6));
    cfg.run_cycles   = counter_t'($urandom_range(20, 300));

    reset_walker();
    req_seen    = '0;
    rsp_total   = '0;
    rsp_settled = '0;
    max_out     = '0;
    have_last   = 1'b0;
    $display("run %0d stride %0d mask %h interval %0d cycles %0d", index, cfg.stride,
             cfg.mem_mask, cfg.req_interval, cfg.run_cycles);

    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_for_busy(8);
    wait_for_done(int'(cfg.run_cycles) + 5000);

    // Results at the done pulse
    check_count("rsp_count", result.rsp_count, rsp_total);
    check_count("responses returned", rsp_total, req_seen);
    if (due_q.size() != 0)
    begin
        report_error("reads still outstanding at done");
    end
    check_count("inflight_max", result.inflight_max, max_out);
    if (result.cycles_executed < cfg.run_cycles + counter_t'(1))
    begin
        report_error("cycles_executed shorter than the configured run");
    end

    // Engine stays quiet once idle
    repeat ($urandom_range(2, 10)) @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("req_valid", req_valid, 1'b0);
endtask

`endif

// File: sim/mem_test_tb.sv
// Testbench for the memory read-bandwidth test engine
// Random configurations, a random-latency memory model and per-cycle checks against models

`timescale 1ns/10ps

module mem_test_tb
    import mem_test_pkg::*;
();

    // DUT ports
    logic         clk;
    logic         reset;
    test_cfg_t    cfg;
    logic         start;
    logic         rd_almost_full = 1'b1;
    logic         rsp_valid = 1'b0;
    logic         req_valid;
    line_addr_t   req_addr;
    logic         busy;
    logic         done;
    test_result_t result;

    // Reference walker state
    line_addr_t   m_off;
    line_addr_t   m_nxt;
    stride_t      m_base;
    logic         m_base_upd;

    // Run bookkeeping
    int           cyc = 0;
    int           last_req_cyc;
    logic         have_last;
    counter_t     req_seen;
    counter_t     rsp_total;
    counter_t     rsp_settled;
    counter_t     max_out;
    logic         rsp_pend = 1'b0;

    // Two-deep almost-full history that lines up with the DUT register
    logic         af_q1 = 1'b1;
    logic         af_q2 = 1'b1;

    // Due cycles of outstanding reads in answer order
    int           due_q[$];

    `include "mem_test_tb_tasks.svh"

    mem_test_top mem_test_top_inst (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .start          (start),
        .rd_almost_full (rd_almost_full),
        .rsp_valid      (rsp_valid),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .busy           (busy),
        .done           (done),
        .result         (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================================
    // Memory model driven on the falling edge
    // ==================================================================

    always @(negedge clk)
    begin
        if (reset)
        begin
            rsp_valid      = 1'b0;
            rd_almost_full = 1'b1;
        end
        else
        begin
            // At most one line returns per cycle
            rsp_valid = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc)
            begin
                void'(due_q.pop_front());
                rsp_valid = 1'b1;
                rsp_total = rsp_total + counter_t'(1);
            end
            // Back-pressure flips now and then
            if ($urandom_range(0, 7) == 0)
            begin
                rd_almost_full = !rd_almost_full;
            end
        end
    end

    // ==================================================================
    // Request monitor sampled on the rising edge
    // ==================================================================

    always @(posedge clk)
    begin : request_monitor
        counter_t outstanding;

        if (!reset)
        begin
            cyc = cyc + 1;
            if (req_valid)
            begin
                check_flag("busy", busy, 1'b1);
                if (af_q2)
                begin
                    report_error("request issued while registered almost-full was high");
                end
                if (have_last && (cyc - last_req_cyc) <= int'(cfg.req_interval))
                begin
                    report_error("request spacing shorter than the pacing interval");
                end
                have_last    = 1'b1;
                last_req_cyc = cyc;
                req_seen     = req_seen + counter_t'(1);
                due_q.push_back(cyc + int'($urandom_range(1, 12)));
            end
            advance_walker(req_valid);

            // Responses count one cycle after they are returned
            outstanding = req_seen - rsp_settled;
            if (outstanding > max_out)
            begin
                max_out = outstanding;
            end
            rsp_settled = rsp_settled + counter_t'(rsp_pend);
            rsp_pend    = rsp_valid;

            af_q2 = af_q1;
            af_q1 = rd_almost_full;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        int run_idx;

        void'($urandom(32'hb2e4_203b));
        reset = 1'b1;
        start = 1'b0;
        cfg   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet engine out of reset
        check_flag("req_valid", req_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);

        for (run_idx = 0; run_idx < 10; run_idx++)
        begin
            run_one_test(run_idx);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hdl
+incdir+sim
hdl/mem_test_pkg.sv
hdl/run_ctrl.sv
hdl/rd_addr_walker.sv
hdl/rd_req_gen.sv
hdl/rsp_stats.sv
hdl/mem_test_top.sv
sim/mem_test_tb.sv
